// File: Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/phase_sequencer.sv
      - verilog/instruction_rom.sv
      - verilog/wide_decoder.sv
      - verilog/execute_stage.sv
      - verilog/cpu_top.sv
  - target: test
    files:
      - testbench/cpu_tb.sv

// File: sources.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/phase_sequencer.sv
verilog/instruction_rom.sv
verilog/wide_decoder.sv
verilog/execute_stage.sv
verilog/cpu_top.sv
testbench/cpu_tb.sv

// File: testbench/cpu_tb.sv
// testbench for cpu_top; loads directed and random programs and checks every write against a model
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int IDLE_WAIT = 12;

    // expected trace of one executed instruction
    typedef struct packed {
        logic [`CPU_ROM_AWIDTH-1:0] pc;
        logic [`CPU_TDEV_W-1:0]     targ;
        logic [`CPU_DATA_W-1:0]     data;
        flags_t                     flags;
    } step_t;

    logic                       clk;
    logic                       arst_n;
    logic                       run;
    logic                       load_we;
    logic [`CPU_ROM_AWIDTH-1:0] load_addr;
    instr_t                     load_word;
    logic [`CPU_ROM_AWIDTH-1:0] pc;
    logic                       wr_strobe;
    logic [`CPU_TDEV_W-1:0]     wr_targ;
    logic [`CPU_DATA_W-1:0]     wr_data;
    flags_t                     flags;

    instr_t                     rom_image [`CPU_ROM_DEPTH];
    logic [`CPU_DATA_W-1:0]     model_regs [`CPU_NREGS];
    logic [`CPU_DATA_W-1:0]     model_ram [`CPU_RAM_DEPTH];
    flags_t                     model_flags;
    logic [`CPU_ROM_AWIDTH-1:0] model_pc;
    logic [15:0]                lfsr_state;
    int                         cycle_count;
    int                         deadline;
    int                         strobe_count;
    int                         last_strobe_cycle;
    int                         n;
    string                      test_name;

    cpu_top cpu_top_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_word (load_word),
        .pc        (pc),
        .wr_strobe (wr_strobe),
        .wr_targ   (wr_targ),
        .wr_data   (wr_data),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_pc(input string name, input logic [`CPU_ROM_AWIDTH-1:0] expected,
                            input logic [`CPU_ROM_AWIDTH-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("[FAIL] %s: pc expected %0h actual %0h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_targ(input string name, input logic [`CPU_TDEV_W-1:0] expected,
                              input logic [`CPU_TDEV_W-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("[FAIL] %s: wr_targ expected %0d actual %0d",
                                     name, expected, actual));
        end
    endtask

    task automatic check_data(input string name, input logic [`CPU_DATA_W-1:0] expected,
                              input logic [`CPU_DATA_W-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("[FAIL] %s: wr_data expected %02h actual %02h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_flags(input string name, input flags_t expected, input flags_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("[FAIL] %s: flags (zero,carry) expected %b actual %b",
                                     name, expected, actual));
        end
    endtask

    // builds a word from fields in the byte lane layout
    function automatic instr_t encode(input logic [4:0] op, input logic [3:0] ad,
                                      input logic [3:0] bd, input logic [4:0] td,
                                      input logic direct, input logic [15:0] addr,
                                      input logic [7:0] imm);
        instr_t w;
        w.b1 = imm;
        w.b2 = addr[7:0];
        w.b3 = addr[15:8];
        w.b4 = {bd[1:0], 5'b0, direct};
        w.b5 = {td[1:0], ad, bd[3:2]};
        w.b6 = {op, td[4:2]};
        return w;
    endfunction

    function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_state[0]};
            lfsr_state = lfsr_advance(lfsr_state);
        end
    endtask

    function automatic logic [7:0] source_value(input logic [3:0] dev, input logic [7:0] imm,
                                                input logic [7:0] raddr);
        if (dev < `CPU_NREGS) begin
            return model_regs[dev[2:0]];
        end
        if (dev == `DEV_IMMED) begin
            return imm;
        end
        if (dev == `DEV_RAM) begin
            return model_ram[raddr];
        end
        return 8'h00;
    endfunction

    // executes the word at model_pc and returns what the write trace must show
    function automatic step_t reference_step();
        instr_t     w;
        step_t      s;
        logic [7:0] imm;
        logic [7:0] raddr;
        logic [7:0] a;
        logic [7:0] b;
        logic [8:0] wide;
        logic [4:0] op;
        logic [4:0] t;
        logic       old_zero;
        w     = rom_image[model_pc];
        imm   = w.b1;
        t     = {w.b6[2:0], w.b5[7:6]};
        op    = w.b6[7:3];
        raddr = w.b4[0] ? w.b2 : model_regs[`CPU_NREGS-1];
        a     = source_value(w.b5[5:2], imm, raddr);
        b     = source_value({w.b5[1:0], w.b4[7:6]}, imm, raddr);
        case (op)
            PASS_B:  wide = {1'b0, b};
            ADD:     wide = {1'b0, a} + {1'b0, b};
            SUB:     wide = {1'b0, a} - {1'b0, b};
            AND:     wide = {1'b0, a & b};
            OR:      wide = {1'b0, a | b};
            XOR:     wide = {1'b0, a ^ b};
            NOT_A:   wide = {1'b0, ~a};
            INC_A:   wide = {1'b0, a} + 9'd1;
            SHL_A:   wide = {a, 1'b0};
            default: wide = {1'b0, a};
        endcase
        s.pc              = model_pc;
        s.targ            = t;
        s.data            = wide[7:0];
        s.flags           = model_flags;
        old_zero          = model_flags.zero;
        model_flags.zero  = (wide[7:0] == 8'h00);
        model_flags.carry = (op == ADD || op == SUB || op == INC_A || op == SHL_A) && wide[8];
        if (t < `CPU_NREGS) begin
            model_regs[t[2:0]] = wide[7:0];
        end else if (t == `TDEV_RAM) begin
            model_ram[raddr] = wide[7:0];
        end
        if (t == `TDEV_JMP || (t == `TDEV_JZ && old_zero)) begin
            model_pc = imm;
        end else begin
            model_pc = model_pc + 1'b1;
        end
        return s;
    endfunction

    task automatic arm_watchdog(input int cycles);
        deadline = cycle_count + cycles;
    endtask

    task automatic load_program(input string name, input int count);
        test_name = name;
        arm_watchdog(count + 20);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= 8'(i);
            load_word <= rom_image[i];
            @(negedge clk);
            if (wr_strobe) begin
                report_failure($sformatf("wr_strobe rose while loading in test %s", test_name));
            end
            check_pc(test_name, '0, pc);
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    // runs until count strobes and lowers run with one more instruction in flight
    task automatic run_program(input string name, input int count);
        test_name         = name;
        model_pc          = '0;
        strobe_count      = 0;
        last_strobe_cycle = -1;
        arm_watchdog((count + 1) * 3 + 20 + IDLE_WAIT);
        @(posedge clk);
        run <= 1'b1;
        while (strobe_count < count) begin
            @(posedge clk);
        end
        run <= 1'b0;
        repeat (IDLE_WAIT) @(posedge clk);
        if (strobe_count != count + 1) begin
            report_failure($sformatf("test %s: %0d strobes seen after run was lowered, not 1",
                                     name, strobe_count - count));
        end
        @(negedge clk);
        check_pc(name, '0, pc);
    endtask

    task automatic build_alu_program(output int len);
        rom_image[0] = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_R1, 1'b0, 16'h0, 8'h5A);
        rom_image[1] = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_R2, 1'b0, 16'h0, 8'hC3);
        for (int op = 0; op <= 9; op++) begin
            rom_image[2 + op] = encode(5'(op), `DEV_R1, `DEV_R2, 5'(3 + op % 5),
                                       1'b0, 16'h0, 8'h00);
        end
        rom_image[12] = encode(SUB, `DEV_R1, `DEV_R1, `TDEV_R4, 1'b0, 16'h0, 8'h00);
        rom_image[13] = encode(PASS_B, `DEV_R0, `DEV_IMMED, `TDEV_R5, 1'b0, 16'h0, 8'hFF);
        rom_image[14] = encode(INC_A, `DEV_R5, `DEV_R0, `TDEV_R6, 1'b0, 16'h0, 8'h00);
        rom_image[15] = encode(SHL_A, `DEV_R2, `DEV_R0, `TDEV_R7, 1'b0, 16'h0, 8'h00);
        // unlisted opcode falls back to pass a
        rom_image[16] = encode(5'd17, `DEV_R1, `DEV_R2, `TDEV_R0, 1'b0, 16'h0, 8'h00);
        rom_image[17] = encode(XOR, `DEV_R7, `DEV_R3, `TDEV_NONE, 1'b0, 16'h0, 8'h00);
        len = 18;
    endtask

    task automatic build_ram_program(output int len);
        rom_image[0] = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_RAM, 1'b1, 16'h1234, 8'h77);
        rom_image[1] = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_R7, 1'b0, 16'h0, 8'h34);
        rom_image[2] = encode(PASS_B, `DEV_R0, `DEV_RAM, `TDEV_R1, 1'b0, 16'h0, 8'h00);
        rom_image[3] = encode(ADD, `DEV_RAM, `DEV_IMMED, `TDEV_R2, 1'b1, 16'h0034, 8'h10);
        rom_image[4] = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_RAM, 1'b0, 16'h0, 8'h99);
        rom_image[5] = encode(PASS_A, `DEV_RAM, `DEV_R0, `TDEV_R3, 1'b1, 16'hFF34, 8'h00);
        rom_image[6] = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_R7, 1'b0, 16'h0, 8'h35);
        rom_image[7] = encode(PASS_A, `DEV_RAM, `DEV_R0, `TDEV_R4, 1'b0, 16'h0, 8'h00);
        len = 8;
    endtask

    // skipped slots write r6 so a missed jump shows up
    task automatic build_jump_program(output int len);
        for (int i = 1; i < 10; i++) begin
            rom_image[i] = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_R6, 1'b0, 16'h0, 8'hEE);
        end
        rom_image[0]  = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_JMP, 1'b0, 16'h0, 8'd5);
        rom_image[5]  = encode(SUB, `DEV_R1, `DEV_R1, `TDEV_R0, 1'b0, 16'h0, 8'h00);
        rom_image[6]  = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_JZ, 1'b0, 16'h0, 8'd10);
        rom_image[10] = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_R0, 1'b0, 16'h0, 8'h01);
        rom_image[11] = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_JZ, 1'b0, 16'h0, 8'd20);
        rom_image[12] = encode(PASS_A, `DEV_IMMED, `DEV_R0, `TDEV_R1, 1'b0, 16'h0, 8'h00);
        len = 13;
    endtask

    task automatic build_random_program();
        instr_t w;
        for (int i = 0; i < `CPU_ROM_DEPTH; i++) begin
            random_byte(w.b1);
            random_byte(w.b2);
            random_byte(w.b3);
            random_byte(w.b4);
            random_byte(w.b5);
            random_byte(w.b6);
            rom_image[i] = w;
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > deadline) begin
                report_failure($sformatf("timeout: test %s did not finish within its cycle budget",
                                         test_name));
            end
        end
    end

    // check each write against the model and the 3 cycle spacing of exec phases
    initial begin
        step_t expected;
        forever begin
            @(negedge clk);
            if (arst_n && wr_strobe) begin
                expected = reference_step();
                check_pc(test_name, expected.pc, pc);
                check_targ(test_name, expected.targ, wr_targ);
                check_data(test_name, expected.data, wr_data);
                check_flags(test_name, expected.flags, flags);
                if (last_strobe_cycle >= 0 && cycle_count - last_strobe_cycle != 3) begin
                    report_failure($sformatf("test %s: wr_strobe came %0d cycles after the last",
                                             test_name, cycle_count - last_strobe_cycle));
                end
                last_strobe_cycle = cycle_count;
                strobe_count++;
            end
        end
    end

    initial begin
        arst_n    <= 1'b0;
        run       <= 1'b0;
        load_we   <= 1'b0;
        load_addr <= '0;
        load_word <= '0;
        for (int i = 0; i < `CPU_NREGS; i++) begin
            model_regs[i] = 8'h00;
        end
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
            model_ram[i] = 8'h00;
        end
        model_flags       = '0;
        model_pc          = '0;
        lfsr_state        = 16'd8;
        cycle_count       = 0;
        deadline          = 40;
        strobe_count      = 0;
        last_strobe_cycle = -1;
        test_name         = "reset";
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // every rom word gets a fill that carries its own address
        for (int i = 0; i < `CPU_ROM_DEPTH; i++) begin
            rom_image[i] = encode(PASS_A, `DEV_IMMED, 4'd10, `TDEV_NONE, 1'b0, 16'(i), 8'(i));
        end
        load_program("idle_after_reset", `CPU_ROM_DEPTH);

        build_alu_program(n);
        load_program("alu_ops", n);
        run_program("alu_ops", n);

        build_ram_program(n);
        load_program("immed_and_ram", n);
        run_program("immed_and_ram", n);

        build_jump_program(n);
        load_program("jmp_and_jz", n);
        run_program("jmp_and_jz", 6);

        build_random_program();
        load_program("random_program", `CPU_ROM_DEPTH);
        run_program("random_program", 200);

        build_alu_program(n);
        load_program("reload_restart", n);
        run_program("reload_restart", n);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verilog/cpu_consts.svh
// shared widths, device numbers and memory sizes; include wherever a CPU_ or DEV_ macro is used
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// widths
`define CPU_ROM_AWIDTH 8
`define CPU_ROM_DEPTH  (1 << `CPU_ROM_AWIDTH)
`define CPU_DATA_W     8
`define CPU_DEV_W      4
`define CPU_TDEV_W     5
`define CPU_NREGS      8
`define CPU_RAM_AWIDTH 8
`define CPU_RAM_DEPTH  (1 << `CPU_RAM_AWIDTH)

// A and B bus sources
`define DEV_R0    0
`define DEV_R1    1
`define DEV_R2    2
`define DEV_R3    3
`define DEV_R4    4
`define DEV_R5    5
`define DEV_R6    6
`define DEV_R7    7
`define DEV_IMMED 8
`define DEV_RAM   9

// write targets
`define TDEV_R0   0
`define TDEV_R1   1
`define TDEV_R2   2
`define TDEV_R3   3
`define TDEV_R4   4
`define TDEV_R5   5
`define TDEV_R6   6
`define TDEV_R7   7
`define TDEV_RAM  8
`define TDEV_JMP  9
`define TDEV_JZ   10
`define TDEV_NONE 31

`endif

// File: verilog/cpu_pkg.sv
// phase and ALU opcode enums plus the instruction, decoded field and select structs of the core
`include "cpu_consts.svh"

package cpu_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        FETCH  = 2'd1,
        DECODE = 2'd2,
        EXEC   = 2'd3
    } phase_e;

    // codes above SHL_A run as PASS_A
    typedef enum logic [4:0] {
        PASS_A = 5'd0,
        PASS_B = 5'd1,
        ADD    = 5'd2,
        SUB    = 5'd3,
        AND    = 5'd4,
        OR     = 5'd5,
        XOR    = 5'd6,
        NOT_A  = 5'd7,
        INC_A  = 5'd8,
        SHL_A  = 5'd9
    } alu_op_e;

    // one byte per rom lane, b1 in the low bits
    typedef struct packed {
        logic [`CPU_DATA_W-1:0] b6;
        logic [`CPU_DATA_W-1:0] b5;
        logic [`CPU_DATA_W-1:0] b4;
        logic [`CPU_DATA_W-1:0] b3;
        logic [`CPU_DATA_W-1:0] b2;
        logic [`CPU_DATA_W-1:0] b1;
    } instr_t;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0]   immed8;
        logic [2*`CPU_DATA_W-1:0] direct_addr;
        logic                     addrmode_direct;
        alu_op_e                  alu_op;
        logic [`CPU_DEV_W-1:0]    abus_dev;
        logic [`CPU_DEV_W-1:0]    bbus_dev;
        logic [`CPU_TDEV_W-1:0]   targ_dev;
    } decoded_t;

    // all active low, one bit per device number
    typedef struct packed {
        logic [(1 << `CPU_DEV_W)-1:0]  lsel;
        logic [(1 << `CPU_DEV_W)-1:0]  rsel;
        logic [(1 << `CPU_TDEV_W)-1:0] tsel;
    } sel_t;

    typedef struct packed {
        logic zero;
        logic carry;
    } flags_t;

endpackage

// File: verilog/cpu_top.sv
// core top level: sequencer, rom, decoder and execute stage with the program load port
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       run,
    input  logic                       load_we,
    input  logic [`CPU_ROM_AWIDTH-1:0] load_addr,
    input  cpu_pkg::instr_t            load_word,
    output logic [`CPU_ROM_AWIDTH-1:0] pc,
    output logic                       wr_strobe,
    output logic [`CPU_TDEV_W-1:0]     wr_targ,
    output logic [`CPU_DATA_W-1:0]     wr_data,
    output cpu_pkg::flags_t            flags
);
    import cpu_pkg::*;

    phase_e                     phase;
    instr_t                     instr;
    decoded_t                   dec;
    sel_t                       sel;
    logic                       jump_en;
    logic [`CPU_ROM_AWIDTH-1:0] jump_addr;

    phase_sequencer phase_sequencer_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .jump_en   (jump_en),
        .jump_addr (jump_addr),
        .phase     (phase),
        .pc        (pc)
    );

    instruction_rom instruction_rom_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .phase     (phase),
        .pc        (pc),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_word (load_word),
        .instr     (instr)
    );

    wide_decoder wide_decoder_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .phase  (phase),
        .instr  (instr),
        .dec    (dec),
        .sel    (sel)
    );

    execute_stage execute_stage_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .phase     (phase),
        .dec       (dec),
        .sel       (sel),
        .jump_en   (jump_en),
        .jump_addr (jump_addr),
        .wr_strobe (wr_strobe),
        .wr_targ   (wr_targ),
        .wr_data   (wr_data),
        .flags     (flags)
    );

endmodule

// File: verilog/execute_stage.sv
// register file, data ram, alu and flags; performs the single bus transfer of each exec phase
`timescale 1ns/100ps
`include "cpu_consts.svh"

module execute_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  cpu_pkg::phase_e            phase,
    input  cpu_pkg::decoded_t          dec,
    input  cpu_pkg::sel_t              sel,
    output logic                       jump_en,
    output logic [`CPU_ROM_AWIDTH-1:0] jump_addr,
    output logic                       wr_strobe,
    output logic [`CPU_TDEV_W-1:0]     wr_targ,
    output logic [`CPU_DATA_W-1:0]     wr_data,
    output cpu_pkg::flags_t            flags
);
    import cpu_pkg::*;

    logic [`CPU_NREGS-1:0][`CPU_DATA_W-1:0] regs;
    logic [`CPU_DATA_W-1:0]                 ram [`CPU_RAM_DEPTH];
    logic [`CPU_RAM_AWIDTH-1:0]             ram_addr;
    logic [`CPU_DATA_W-1:0]                 ram_q;
    logic [`CPU_DATA_W-1:0]                 a_bus;
    logic [`CPU_DATA_W-1:0]                 b_bus;
    logic [`CPU_DATA_W:0]                   alu_wide;
    logic [`CPU_DATA_W-1:0]                 result;
    flags_t                                 flags_next;

    // bus source mux, unselected numbers read zero
    function automatic logic [`CPU_DATA_W-1:0] bus_read(
        input logic [(1 << `CPU_DEV_W)-1:0]           sel_n,
        input logic [`CPU_NREGS-1:0][`CPU_DATA_W-1:0] r,
        input logic [`CPU_DATA_W-1:0]                 imm,
        input logic [`CPU_DATA_W-1:0]                 mem_q
    );
        logic [`CPU_DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < `CPU_NREGS; i++) begin
            if (!sel_n[`DEV_R0 + i]) begin
                v = r[i];
            end
        end
        if (!sel_n[`DEV_IMMED]) begin
            v = imm;
        end
        if (!sel_n[`DEV_RAM]) begin
            v = mem_q;
        end
        return v;
    endfunction

    // register mode addresses ram through r7
    assign ram_addr = dec.addrmode_direct ? dec.direct_addr[`CPU_RAM_AWIDTH-1:0]
                                          : regs[`CPU_NREGS-1];
    assign ram_q    = ram[ram_addr];
    assign a_bus    = bus_read(sel.lsel, regs, dec.immed8, ram_q);
    assign b_bus    = bus_read(sel.rsel, regs, dec.immed8, ram_q);

    always_comb begin
        flags_next.carry = 1'b0;
        case (dec.alu_op)
            PASS_B: alu_wide = {1'b0, b_bus};
            ADD:    alu_wide = {1'b0, a_bus} + {1'b0, b_bus};
            SUB:    alu_wide = {1'b0, a_bus} - {1'b0, b_bus};
            AND:    alu_wide = {1'b0, a_bus & b_bus};
            OR:     alu_wide = {1'b0, a_bus | b_bus};
            XOR:    alu_wide = {1'b0, a_bus ^ b_bus};
            NOT_A:  alu_wide = {1'b0, ~a_bus};
            INC_A:  alu_wide = {1'b0, a_bus} + 1'b1;
            SHL_A:  alu_wide = {a_bus, 1'b0};
            default: alu_wide = {1'b0, a_bus};
        endcase
        // only the arithmetic ops produce a carry
        if (dec.alu_op inside {ADD, SUB, INC_A, SHL_A}) begin
            flags_next.carry = alu_wide[`CPU_DATA_W];
        end
        result          = alu_wide[`CPU_DATA_W-1:0];
        flags_next.zero = (result == '0);
    end

    // jz tests the flags left by the previous instruction
    assign jump_en   = (phase == EXEC) &&
                       (!sel.tsel[`TDEV_JMP] || (!sel.tsel[`TDEV_JZ] && flags.zero));
    assign jump_addr = dec.immed8[`CPU_ROM_AWIDTH-1:0];

    assign wr_strobe = (phase == EXEC);
    assign wr_targ   = dec.targ_dev;
    assign wr_data   = result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs  <= '0;
            flags <= '0;
            for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
                ram[i] <= '0;
            end
        end else if (phase == EXEC) begin
            flags <= flags_next;
            for (int i = 0; i < `CPU_NREGS; i++) begin
                if (!sel.tsel[`TDEV_R0 + i]) begin
                    regs[i] <= result;
                end
            end
            if (!sel.tsel[`TDEV_RAM]) begin
                ram[ram_addr] <= result;
            end
        end
    end

endmodule

// File: verilog/instruction_rom.sv
// six byte-lane program memory, loaded while idle and read into an instruction register at fetch
`timescale 1ns/100ps
`include "cpu_consts.svh"

module instruction_rom (
    input  logic                       clk,
    input  logic                       arst_n,
    input  cpu_pkg::phase_e            phase,
    input  logic [`CPU_ROM_AWIDTH-1:0] pc,
    input  logic                       load_we,
    input  logic [`CPU_ROM_AWIDTH-1:0] load_addr,
    input  cpu_pkg::instr_t            load_word,
    output cpu_pkg::instr_t            instr
);
    import cpu_pkg::*;

    localparam int NLANES = $bits(instr_t) / `CPU_DATA_W;

    logic [`CPU_DATA_W-1:0]             lane_mem [NLANES][`CPU_ROM_DEPTH];
    logic [NLANES-1:0][`CPU_DATA_W-1:0] load_lanes;
    logic [NLANES-1:0][`CPU_DATA_W-1:0] fetch_lanes;

    // lane 0 holds b1
    assign load_lanes = load_word;

    always_ff @(posedge clk) begin
        if (load_we && phase == IDLE) begin
            for (int i = 0; i < NLANES; i++) begin
                lane_mem[i][load_addr] <= load_lanes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase == FETCH) begin
            for (int i = 0; i < NLANES; i++) begin
                fetch_lanes[i] <= lane_mem[i][pc];
            end
        end
    end

    assign instr = instr_t'(fetch_lanes);

    // program loads only while the sequencer is parked
    a_load_in_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        load_we |-> phase == IDLE
    );

endmodule

// File: verilog/phase_sequencer.sv
// fetch/decode/exec phase generator and program counter; one instance drives the whole core
`timescale 1ns/100ps
`include "cpu_consts.svh"

module phase_sequencer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       run,
    input  logic                       jump_en,
    input  logic [`CPU_ROM_AWIDTH-1:0] jump_addr,
    output cpu_pkg::phase_e            phase,
    output logic [`CPU_ROM_AWIDTH-1:0] pc
);
    import cpu_pkg::*;

    phase_e next_phase;

    always_comb begin
        next_phase = phase;
        unique case (phase)
            IDLE:   next_phase = run ? FETCH : IDLE;
            FETCH:  next_phase = DECODE;
            DECODE: next_phase = EXEC;
            // stop only on an instruction boundary
            EXEC:   next_phase = run ? FETCH : IDLE;
            default: next_phase = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= IDLE;
        end else begin
            phase <= next_phase;
        end
    end

    // pc parks at zero while idle so a restart runs from the top
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (phase == IDLE) begin
            pc <= '0;
        end else if (phase == EXEC) begin
            if (jump_en) begin
                pc <= jump_addr;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    // fetch and decode are single cycle phases
    a_fetch_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        phase == FETCH |=> phase != FETCH
    );
    a_decode_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        phase == DECODE |=> phase != DECODE
    );

endmodule

// File: verilog/wide_decoder.sv
// splits the instruction word into fields and device selects, latched during the decode phase
`timescale 1ns/100ps
`include "cpu_consts.svh"

module wide_decoder (
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::phase_e   phase,
    input  cpu_pkg::instr_t   instr,
    output cpu_pkg::decoded_t dec,
    output cpu_pkg::sel_t     sel
);
    import cpu_pkg::*;

    decoded_t                dec_next;
    sel_t                    sel_next;
    logic [4:0]              alu_raw;
    logic [3:0]              tblock_n;

    // 3-to-8 demux, active low outputs and enable
    function automatic logic [7:0] demux8_n(input logic en_n, input logic [2:0] a);
        logic [7:0] y;
        y = '1;
        if (!en_n) begin
            y[a] = 1'b0;
        end
        return y;
    endfunction

    // 2-to-4 demux, always enabled
    function automatic logic [3:0] demux4_n(input logic [1:0] a);
        logic [3:0] y;
        y = '1;
        y[a] = 1'b0;
        return y;
    endfunction

    always_comb begin
        dec_next.immed8          = instr.b1;
        dec_next.direct_addr     = {instr.b3, instr.b2};
        dec_next.addrmode_direct = instr.b4[0];
        dec_next.bbus_dev        = {instr.b5[1:0], instr.b4[7:6]};
        dec_next.abus_dev        = instr.b5[5:2];
        dec_next.targ_dev        = {instr.b6[2:0], instr.b5[7:6]};
        alu_raw                  = instr.b6[7:3];
        if (alu_raw > 5'(SHL_A)) begin
            dec_next.alu_op = PASS_A;
        end else begin
            dec_next.alu_op = alu_op_e'(alu_raw);
        end
    end

    always_comb begin
        // bit 3 picks which half of the 16 sources is live
        sel_next.lsel = {demux8_n(~dec_next.abus_dev[3], dec_next.abus_dev[2:0]),
                         demux8_n(dec_next.abus_dev[3], dec_next.abus_dev[2:0])};
        sel_next.rsel = {demux8_n(~dec_next.bbus_dev[3], dec_next.bbus_dev[2:0]),
                         demux8_n(dec_next.bbus_dev[3], dec_next.bbus_dev[2:0])};
        // target: block select then four 8-way decodes
        tblock_n      = demux4_n(dec_next.targ_dev[4:3]);
        sel_next.tsel = {demux8_n(tblock_n[3], dec_next.targ_dev[2:0]),
                         demux8_n(tblock_n[2], dec_next.targ_dev[2:0]),
                         demux8_n(tblock_n[1], dec_next.targ_dev[2:0]),
                         demux8_n(tblock_n[0], dec_next.targ_dev[2:0])};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec <= '0;
            sel <= '1;
        end else if (phase == DECODE) begin
            dec <= dec_next;
            sel <= sel_next;
        end
    end

    // exactly one device on each bus while executing
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        phase == EXEC |-> ($onehot(~sel.lsel) && $onehot(~sel.rsel) && $onehot(~sel.tsel))
    );

endmodule
